/* Makefile */
TOP = tb_ring_controller

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f filelist.f --top-module $(TOP)

obj_dir/V$(TOP): filelist.f verilog/*.sv verilog/*.svh dv/*.sv
	verilator --binary --timing --timescale 1ns/1ps -f filelist.f --top-module $(TOP) -o V$(TOP)

# Fails when the log holds the fail message or lacks the pass message
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	! grep -q "sim failed" sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/tb_ring_checks.sv */
/*
 * Checker for ring_controller that the testbench top instantiates.
 * Samples on the falling clock edge, while DUT outputs are stable.
 * Any ack packet for this core is taken as a consumed response.
 */
`timescale 1ns/1ps
`include "ring_params.svh"

module tb_ring_checks
	#(parameter CORE_ID = 1)
	(input clk,
	input reset,
	input ring_pkg::ring_packet_t packet_in,
	input ring_pkg::ring_packet_t packet_out,
	input dcache_miss,
	input ring_pkg::scalar_t dcache_miss_addr,
	input dcache_miss_store,
	input ring_pkg::thread_idx_t dcache_miss_thread,
	input icache_miss,
	input ring_pkg::scalar_t icache_miss_addr,
	input ring_pkg::thread_idx_t icache_miss_thread,
	input [`THREADS_PER_CORE - 1:0] dcache_wake_oh,
	input [`THREADS_PER_CORE - 1:0] icache_wake_oh,
	input dcache_snoop_en,
	input ring_pkg::l1d_set_idx_t dcache_snoop_set,
	input icache_lru_read_en,
	input ring_pkg::l1i_set_idx_t icache_lru_read_set,
	output int mismatch_count,
	output int other_count,
	output int outstanding_count);

	import ring_pkg::*;

	localparam NT = `THREADS_PER_CORE;

	// Scoreboard indexed by cache (0 icache, 1 dcache) and thread
	logic sb_busy[2][NT];
	logic sb_sent[2][NT];
	logic sb_store[2][NT];
	scalar_t sb_addr[2][NT];
	int sb_issue_cyc[2][NT];

	// packet_in one, two and three cycles back
	ring_packet_t in_hist0;
	ring_packet_t in_hist1;
	ring_packet_t in_hist2;
	logic after_reset;
	int cyc;

	initial
	begin
		mismatch_count = 0;
		other_count = 0;
		outstanding_count = 0;
		after_reset = 1'b0;
	end

	function automatic logic [25:0] line_of(scalar_t a);
		return a[31:6];
	endfunction

	function automatic logic is_response(ring_packet_t p);
		return p.valid && p.ack && p.dest_core == core_id_t'(CORE_ID);
	endfunction

	task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
		mismatch_count++;
		$display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
	endtask

	task automatic report_failure(string what);
		other_count++;
		$display("error at %0t: %s", $time, what);
	endtask

	// Set index sits right above the 64-byte line offset
	task automatic check_snoop();
		logic want_dcache;
		logic want_icache;
		want_dcache = packet_in.valid && packet_in.cache_type == CT_DCACHE;
		want_icache = packet_in.valid && packet_in.cache_type == CT_ICACHE;
		assert (dcache_snoop_en == want_dcache)
		else report_mismatch("dcache_snoop_en", 64'(want_dcache), 64'(dcache_snoop_en));
		assert (icache_lru_read_en == want_icache)
		else report_mismatch("icache_lru_read_en", 64'(want_icache), 64'(icache_lru_read_en));
		if (dcache_snoop_en)
		begin
			assert (dcache_snoop_set == packet_in.address[11:6])
			else report_mismatch("dcache_snoop_set", 64'(packet_in.address[11:6]),
				64'(dcache_snoop_set));
		end
		if (icache_lru_read_en)
		begin
			assert (icache_lru_read_set == packet_in.address[11:6])
			else report_mismatch("icache_lru_read_set", 64'(packet_in.address[11:6]),
				64'(icache_lru_read_set));
		end
	endtask

	task automatic check_request(ring_packet_t p);
		int c;
		logic found;
		logic addr_ok;
		logic want_store;
		c = int'(p.cache_type);
		found = 1'b0;
		addr_ok = 1'b0;
		want_store = 1'b0;
		assert (p.ack == 1'b0)
		else report_mismatch("request ack", 64'(0), 64'(p.ack));
		assert (p.dest_core == core_id_t'(CORE_ID))
		else report_mismatch("request dest_core", 64'(CORE_ID), 64'(p.dest_core));

		// Miss must have been queued before the empty slot was sampled
		for (int t = 0; t < NT; t++)
		begin
			if (sb_busy[c][t] && !sb_sent[c][t] && sb_issue_cyc[c][t] < cyc - 2
				&& line_of(sb_addr[c][t]) == line_of(p.address))
			begin
				found = 1'b1;
				want_store = sb_store[c][t];
				if (sb_addr[c][t] == p.address)
					addr_ok = 1'b1;
			end
		end
		if (!found)
			report_failure("request on the ring matches no waiting unsent miss");
		else
		begin
			assert (addr_ok)
			else report_failure("request address differs from every miss on its line");
			assert (p.packet_type == (want_store ? PKT_WRITE_INVALIDATE : PKT_READ_SHARED))
			else report_mismatch("request packet_type", 64'(want_store), 64'(p.packet_type));
		end

		// Merged threads ride on the same request
		for (int t = 0; t < NT; t++)
		begin
			if (sb_busy[c][t] && line_of(sb_addr[c][t]) == line_of(p.address))
				sb_sent[c][t] = 1'b1;
		end

		// Data misses win the slot
		if (p.cache_type == CT_ICACHE)
		begin
			for (int t = 0; t < NT; t++)
			begin
				if (sb_busy[1][t] && !sb_sent[1][t] && sb_issue_cyc[1][t] < cyc - 2)
					report_failure("instruction request went out while a data miss waited");
			end
		end
	endtask

	// Ring output follows packet_in of two cycles back
	task automatic check_ring_out();
		if (is_response(in_hist1))
		begin
			assert (!packet_out.valid)
			else report_mismatch("packet_out.valid", 64'(0), 64'(packet_out.valid));
		end
		else if (in_hist1.valid)
		begin
			assert (packet_out == in_hist1)
			else report_mismatch("packet_out", 64'(in_hist1), 64'(packet_out));
		end
		else if (packet_out.valid)
			check_request(packet_out);
	endtask

	// Wake lands three cycles after the response was on packet_in
	task automatic check_wake(int c, logic [NT - 1:0] mask);
		logic [NT - 1:0] expected;
		expected = '0;
		if (is_response(in_hist2) && int'(in_hist2.cache_type) == c)
		begin
			for (int t = 0; t < NT; t++)
			begin
				if (sb_busy[c][t] && sb_sent[c][t]
					&& line_of(sb_addr[c][t]) == line_of(in_hist2.address))
					expected[t] = 1'b1;
			end
		end
		assert (mask == expected)
		else report_mismatch(c == 1 ? "dcache_wake_oh" : "icache_wake_oh",
			64'(expected), 64'(mask));
		for (int t = 0; t < NT; t++)
		begin
			if (expected[t] || mask[t])
				sb_busy[c][t] = 1'b0;
		end
	endtask

	task automatic record_miss(int c, int t, scalar_t a, logic st);
		logic owner_sent;
		logic owner_store;
		owner_sent = 1'b0;
		owner_store = st;

		// A line already queued keeps its first request state
		for (int u = 0; u < NT; u++)
		begin
			if (sb_busy[c][u] && u != t && line_of(sb_addr[c][u]) == line_of(a))
			begin
				owner_sent = sb_sent[c][u];
				owner_store = sb_store[c][u];
			end
		end
		sb_busy[c][t] = 1'b1;
		sb_sent[c][t] = owner_sent;
		sb_store[c][t] = owner_store;
		sb_addr[c][t] = a;
		sb_issue_cyc[c][t] = cyc;
	endtask

	always @(negedge clk)
	begin
		if (reset || after_reset)
		begin
			assert (!packet_out.valid)
			else report_mismatch("packet_out.valid", 64'(0), 64'(packet_out.valid));
			assert (dcache_wake_oh == '0)
			else report_mismatch("dcache_wake_oh", 64'(0), 64'(dcache_wake_oh));
			assert (icache_wake_oh == '0)
			else report_mismatch("icache_wake_oh", 64'(0), 64'(icache_wake_oh));
		end

		if (reset)
		begin
			after_reset = 1'b1;
			cyc = 0;
			in_hist0 = '0;
			in_hist1 = '0;
			in_hist2 = '0;
			for (int c = 0; c < 2; c++)
			begin
				for (int t = 0; t < NT; t++)
				begin
					sb_busy[c][t] = 1'b0;
					sb_sent[c][t] = 1'b0;
				end
			end
		end
		else
		begin
			after_reset = 1'b0;
			cyc++;
			check_snoop();
			check_ring_out();
			check_wake(1, dcache_wake_oh);
			check_wake(0, icache_wake_oh);

			// Wakes go first so that a miss in the wake cycle opens a new entry
			if (dcache_miss)
				record_miss(1, int'(dcache_miss_thread), dcache_miss_addr, dcache_miss_store);
			if (icache_miss)
				record_miss(0, int'(icache_miss_thread), icache_miss_addr, 1'b0);

			in_hist2 = in_hist1;
			in_hist1 = in_hist0;
			in_hist0 = packet_in;
			outstanding_count = 0;
			for (int c = 0; c < 2; c++)
			begin
				for (int t = 0; t < NT; t++)
				begin
					if (sb_busy[c][t])
						outstanding_count++;
				end
			end
		end
	end
endmodule

/* dv/tb_ring_controller.sv */
/*
 * Testbench for ring_controller with CORE_ID 1. An L2 model answers
 * each request after 3 to 10 cycles or more, and fills other slots
 * with traffic for other cores. Checks live in tb_ring_checks.
 */
`timescale 1ns/1ps
`include "ring_params.svh"

module tb_ring_controller;
	import ring_pkg::*;

	localparam CORE_ID = 1;
	localparam CLK_PERIOD = 4;
	localparam STIM_CYCLES = 1500;
	localparam DRAIN_CYCLES = 2500;
	localparam WATCHDOG_CYCLES = STIM_CYCLES + DRAIN_CYCLES;
	localparam NT = `THREADS_PER_CORE;

	logic clk;
	logic reset;
	ring_packet_t packet_in;
	ring_packet_t packet_out;
	logic dcache_miss;
	scalar_t dcache_miss_addr;
	logic dcache_miss_store;
	thread_idx_t dcache_miss_thread;
	logic icache_miss;
	scalar_t icache_miss_addr;
	thread_idx_t icache_miss_thread;
	logic [NT - 1:0] dcache_wake_oh;
	logic [NT - 1:0] icache_wake_oh;
	logic dcache_snoop_en;
	l1d_set_idx_t dcache_snoop_set;
	logic icache_lru_read_en;
	l1i_set_idx_t icache_lru_read_set;
	int mismatch_count;
	int other_count;
	int outstanding_count;

	logic [31:0] lfsr;
	int cyc;
	int leftover;
	// Misses issued and woken per cache (0 icache, 1 dcache) and thread
	int issued[2][NT];
	int woken[2][NT];
	scalar_t last_addr[2][NT];
	// L2 model request queue
	ring_packet_t req_q[$];
	int seen_q[$];
	int head_due;

	ring_controller #(.CORE_ID(CORE_ID)) i_ring_controller(
		.clk(clk),
		.reset(reset),
		.packet_in(packet_in),
		.packet_out(packet_out),
		.dcache_miss(dcache_miss),
		.dcache_miss_addr(dcache_miss_addr),
		.dcache_miss_store(dcache_miss_store),
		.dcache_miss_thread(dcache_miss_thread),
		.dcache_wake_oh(dcache_wake_oh),
		.dcache_snoop_en(dcache_snoop_en),
		.dcache_snoop_set(dcache_snoop_set),
		.icache_miss(icache_miss),
		.icache_miss_addr(icache_miss_addr),
		.icache_miss_thread(icache_miss_thread),
		.icache_wake_oh(icache_wake_oh),
		.icache_lru_read_en(icache_lru_read_en),
		.icache_lru_read_set(icache_lru_read_set));

	tb_ring_checks #(.CORE_ID(CORE_ID)) checks(
		.clk(clk),
		.reset(reset),
		.packet_in(packet_in),
		.packet_out(packet_out),
		.dcache_miss(dcache_miss),
		.dcache_miss_addr(dcache_miss_addr),
		.dcache_miss_store(dcache_miss_store),
		.dcache_miss_thread(dcache_miss_thread),
		.icache_miss(icache_miss),
		.icache_miss_addr(icache_miss_addr),
		.icache_miss_thread(icache_miss_thread),
		.dcache_wake_oh(dcache_wake_oh),
		.icache_wake_oh(icache_wake_oh),
		.dcache_snoop_en(dcache_snoop_en),
		.dcache_snoop_set(dcache_snoop_set),
		.icache_lru_read_en(icache_lru_read_en),
		.icache_lru_read_set(icache_lru_read_set),
		.mismatch_count(mismatch_count),
		.other_count(other_count),
		.outstanding_count(outstanding_count));

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	function automatic logic is_busy(int c, int t);
		return issued[c][t] != woken[c][t];
	endfunction

	function automatic logic any_busy();
		for (int c = 0; c < 2; c++)
		begin
			for (int t = 0; t < NT; t++)
			begin
				if (is_busy(c, t))
					return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// Sometimes share a line with another waiting thread to get merges
	function automatic scalar_t pick_addr(int c, int t);
		logic [31:0] bits;
		int u;
		bits = take_bits(3);
		u = int'(bits[1:0]);
		if (bits[2] && u != t && is_busy(c, u))
		begin
			bits = take_bits(6);
			return {last_addr[c][u][31:6], bits[5:0]};
		end
		return take_bits(32);
	endfunction

	// Wake masks and requests of the current cycle
	task automatic observe();
		for (int t = 0; t < NT; t++)
		begin
			if (dcache_wake_oh[t] && is_busy(1, t))
				woken[1][t]++;
			if (icache_wake_oh[t] && is_busy(0, t))
				woken[0][t]++;
		end
		if (packet_out.valid && !packet_out.ack && packet_out.dest_core == core_id_t'(CORE_ID))
		begin
			req_q.push_back(packet_out);
			seen_q.push_back(cyc);
		end
	endtask

	task automatic drive_misses(logic issue);
		logic [31:0] bits;
		int t;
		dcache_miss = 1'b0;
		icache_miss = 1'b0;
		if (issue)
		begin
			bits = take_bits(3);
			t = int'(bits[1:0]);
			if (bits[2] && !is_busy(1, t))
			begin
				dcache_miss = 1'b1;
				dcache_miss_thread = thread_idx_t'(t);
				dcache_miss_addr = pick_addr(1, t);
				bits = take_bits(1);
				dcache_miss_store = bits[0];
				last_addr[1][t] = dcache_miss_addr;
				issued[1][t]++;
			end
			bits = take_bits(3);
			t = int'(bits[1:0]);
			if (bits[2] && !is_busy(0, t))
			begin
				icache_miss = 1'b1;
				icache_miss_thread = thread_idx_t'(t);
				icache_miss_addr = pick_addr(0, t);
				last_addr[0][t] = icache_miss_addr;
				issued[0][t]++;
			end
		end
	endtask

	// L2 answers in request order and leaves other slots empty or foreign
	task automatic drive_ring();
		logic [31:0] bits;
		ring_packet_t p;
		p = '0;
		if (req_q.size() > 0 && head_due < 0)
		begin
			bits = take_bits(3);
			head_due = seen_q[0] + 3 + int'(bits[2:0]);
		end
		bits = take_bits(2);
		if (req_q.size() > 0 && cyc >= head_due && bits[0])
		begin
			p = req_q.pop_front();
			void'(seen_q.pop_front());
			head_due = -1;
			p.ack = 1'b1;
		end
		else if (bits[1:0] == 2'b10)
		begin
			p.address = take_bits(32);
			bits = take_bits(5);
			p.valid = 1'b1;
			p.packet_type = packet_type_t'(bits[0]);
			p.ack = bits[1];
			p.cache_type = cache_type_t'(bits[2]);
			p.dest_core = core_id_t'(bits[4:3]);
			if (p.dest_core == core_id_t'(CORE_ID))
				p.dest_core = core_id_t'(3);
		end
		packet_in = p;
	endtask

	task automatic step(logic issue);
		@(posedge clk);
		#1;
		observe();
		drive_misses(issue);
		drive_ring();
		cyc++;
	endtask

	initial
	begin
		lfsr = 32'h5c946c2c;
		cyc = 0;
		leftover = 0;
		head_due = -1;
		reset = 1'b1;
		packet_in = '0;
		dcache_miss = 1'b0;
		dcache_miss_addr = '0;
		dcache_miss_store = 1'b0;
		dcache_miss_thread = '0;
		icache_miss = 1'b0;
		icache_miss_addr = '0;
		icache_miss_thread = '0;
		for (int c = 0; c < 2; c++)
		begin
			for (int t = 0; t < NT; t++)
			begin
				issued[c][t] = 0;
				woken[c][t] = 0;
				last_addr[c][t] = '0;
			end
		end
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;

		for (int i = 0; i < STIM_CYCLES; i++)
			step(1'b1);

		// L2 keeps answering until every thread is woken
		while (any_busy())
			step(1'b0);
		repeat (10) step(1'b0);

		if (outstanding_count != 0)
		begin
			$display("error: %0d misses were never woken", outstanding_count);
			leftover = 1;
		end
		$display("errors: %0d mismatch, %0d other", mismatch_count, other_count + leftover);
		if (mismatch_count == 0 && other_count + leftover == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Watchdog covers stimulus plus drain
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("error: watchdog expired after %0d cycles, misses still waiting",
			WATCHDOG_CYCLES);
		$display("errors: %0d mismatch, %0d other", mismatch_count, other_count + 1);
		$display("sim failed");
		$finish;
	end
endmodule

/* filelist.f */
+incdir+verilog
verilog/ring_pkg.sv
verilog/ring_if.sv
verilog/l1_miss_queue.sv
verilog/ring_controller_stage1.sv
verilog/ring_response_stage.sv
verilog/ring_controller.sv
dv/tb_ring_checks.sv
dv/tb_ring_controller.sv

/* verilog/l1_miss_queue.sv */
/*
 * Pending L1 misses, one entry per thread. A requester must stay
 * stalled until woken, it never enqueues twice for one miss.
 * Misses to a line already queued merge into that entry.
 */
`timescale 1ns/1ps
`include "ring_params.svh"

module l1_miss_queue(
	input clk,
	input reset,

	// New miss from the cache
	input enqueue_en,
	input ring_pkg::scalar_t enqueue_addr,
	input ring_pkg::thread_idx_t enqueue_thread_idx,
	input ring_pkg::pending_miss_state_t enqueue_state,

	// Oldest unsent request
	output logic dequeue_ready,
	output ring_pkg::scalar_t dequeue_addr,
	output ring_pkg::pending_miss_state_t dequeue_state,
	input dequeue_en,

	// Lookup of a passing packet
	input snoop_en,
	input ring_pkg::scalar_t snoop_addr,
	output logic snoop_request_pending,
	output ring_pkg::l1_miss_entry_idx_t snoop_pending_entry,
	output ring_pkg::pending_miss_state_t snoop_state,

	// Completion
	input wake_en,
	input ring_pkg::l1_miss_entry_idx_t wake_entry,
	output logic [`THREADS_PER_CORE - 1:0] wake_oh);

	import ring_pkg::*;

	localparam NUM_ENTRIES = `THREADS_PER_CORE;

	logic [NUM_ENTRIES - 1:0] entry_valid;
	logic [NUM_ENTRIES - 1:0] entry_sent;
	scalar_t entry_addr[NUM_ENTRIES];
	pending_miss_state_t entry_state[NUM_ENTRIES];
	logic [`THREADS_PER_CORE - 1:0] entry_waiting[NUM_ENTRIES];
	logic merge;
	l1_miss_entry_idx_t merge_entry;
	l1_miss_entry_idx_t dequeue_entry;
	logic [`THREADS_PER_CORE - 1:0] enqueue_thread_oh;

	function automatic cache_line_index_t line_of(scalar_t addr);
		return addr[`ADDR_WIDTH - 1:CACHE_LINE_OFFSET_WIDTH];
	endfunction

	// Walk down so the lowest matching index wins
	always_comb
	begin
		merge = 1'b0;
		merge_entry = '0;
		snoop_request_pending = 1'b0;
		snoop_pending_entry = '0;
		dequeue_ready = 1'b0;
		dequeue_entry = '0;
		for (int i = NUM_ENTRIES - 1; i >= 0; i--)
		begin
			// An entry being woken this cycle no longer takes merges
			if (entry_valid[i] && !(wake_en && wake_entry == l1_miss_entry_idx_t'(i))
				&& line_of(entry_addr[i]) == line_of(enqueue_addr))
			begin
				merge = 1'b1;
				merge_entry = l1_miss_entry_idx_t'(i);
			end

			// Only requests already on the ring can have a response
			if (snoop_en && entry_valid[i] && entry_sent[i]
				&& line_of(entry_addr[i]) == line_of(snoop_addr))
			begin
				snoop_request_pending = 1'b1;
				snoop_pending_entry = l1_miss_entry_idx_t'(i);
			end

			if (entry_valid[i] && !entry_sent[i])
			begin
				dequeue_ready = 1'b1;
				dequeue_entry = l1_miss_entry_idx_t'(i);
			end
		end
	end

	always_comb
	begin
		enqueue_thread_oh = '0;
		enqueue_thread_oh[enqueue_thread_idx] = 1'b1;
	end

	assign dequeue_addr = entry_addr[dequeue_entry];
	assign dequeue_state = entry_state[dequeue_entry];
	assign snoop_state = entry_state[snoop_pending_entry];
	assign wake_oh = wake_en ? entry_waiting[wake_entry] : '0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			entry_valid <= '0;
			entry_sent <= '0;
		end
		else
		begin
			if (wake_en)
				entry_valid[wake_entry] <= 1'b0;

			if (dequeue_en)
				entry_sent[dequeue_entry] <= 1'b1;

			// New line fills the entry owned by the missing thread
			if (enqueue_en && !merge)
			begin
				entry_valid[enqueue_thread_idx] <= 1'b1;
				entry_sent[enqueue_thread_idx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (enqueue_en)
		begin
			if (merge)
				entry_waiting[merge_entry] <= entry_waiting[merge_entry] | enqueue_thread_oh;
			else
			begin
				entry_addr[enqueue_thread_idx] <= enqueue_addr;
				entry_state[enqueue_thread_idx] <= enqueue_state;
				entry_waiting[enqueue_thread_idx] <= enqueue_thread_oh;
			end
		end
	end
endmodule

/* verilog/ring_controller.sv */
/*
 * Ring node front for one core. Fixed 2-cycle ring latency, no
 * back-pressure; requests wait for an empty slot.
 */
`timescale 1ns/1ps
`include "ring_params.svh"

module ring_controller
	#(parameter CORE_ID = 0)
	(input clk,
	input reset,

	// Ring
	input ring_pkg::ring_packet_t packet_in,
	output ring_pkg::ring_packet_t packet_out,

	// Data cache
	input dcache_miss,
	input ring_pkg::scalar_t dcache_miss_addr,
	input dcache_miss_store,
	input ring_pkg::thread_idx_t dcache_miss_thread,
	output logic [`THREADS_PER_CORE - 1:0] dcache_wake_oh,
	output logic dcache_snoop_en,
	output ring_pkg::l1d_set_idx_t dcache_snoop_set,

	// Instruction cache
	input icache_miss,
	input ring_pkg::scalar_t icache_miss_addr,
	input ring_pkg::thread_idx_t icache_miss_thread,
	output logic [`THREADS_PER_CORE - 1:0] icache_wake_oh,
	output logic icache_lru_read_en,
	output ring_pkg::l1i_set_idx_t icache_lru_read_set);

	rc1_result_if rc1();
	miss_wake_if wake();

	// Snoop, lookup and injection
	ring_controller_stage1 #(.CORE_ID(CORE_ID)) stage1(
		.clk(clk),
		.reset(reset),
		.packet_in(packet_in),
		.dcache_miss(dcache_miss),
		.dcache_miss_addr(dcache_miss_addr),
		.dcache_miss_store(dcache_miss_store),
		.dcache_miss_thread(dcache_miss_thread),
		.icache_miss(icache_miss),
		.icache_miss_addr(icache_miss_addr),
		.icache_miss_thread(icache_miss_thread),
		.dcache_wake_oh(dcache_wake_oh),
		.icache_wake_oh(icache_wake_oh),
		.dcache_snoop_en(dcache_snoop_en),
		.dcache_snoop_set(dcache_snoop_set),
		.icache_lru_read_en(icache_lru_read_en),
		.icache_lru_read_set(icache_lru_read_set),
		.rc1(rc1.source),
		.wake(wake.sink));

	// Response capture and forwarding
	ring_response_stage #(.CORE_ID(CORE_ID)) stage2(
		.clk(clk),
		.reset(reset),
		.rc1(rc1.sink),
		.wake(wake.source),
		.packet_out(packet_out));
endmodule

/* verilog/ring_controller_stage1.sv */
/*
 * Ring stage 1. Snoops passing packets against both miss queues and
 * injects requests into empty slots only, data cache first.
 */
`timescale 1ns/1ps
`include "ring_params.svh"

module ring_controller_stage1
	#(parameter CORE_ID = 0)
	(input clk,
	input reset,
	input ring_pkg::ring_packet_t packet_in,

	// Data cache miss
	input dcache_miss,
	input ring_pkg::scalar_t dcache_miss_addr,
	input dcache_miss_store,
	input ring_pkg::thread_idx_t dcache_miss_thread,

	// Instruction cache miss
	input icache_miss,
	input ring_pkg::scalar_t icache_miss_addr,
	input ring_pkg::thread_idx_t icache_miss_thread,

	output logic [`THREADS_PER_CORE - 1:0] dcache_wake_oh,
	output logic [`THREADS_PER_CORE - 1:0] icache_wake_oh,
	output logic dcache_snoop_en,
	output ring_pkg::l1d_set_idx_t dcache_snoop_set,
	output logic icache_lru_read_en,
	output ring_pkg::l1i_set_idx_t icache_lru_read_set,

	rc1_result_if.source rc1,
	miss_wake_if.sink wake);

	import ring_pkg::*;

	ring_packet_t packet_nxt;
	l1d_addr_t dcache_addr;
	l1i_addr_t icache_addr;
	logic dcache_dequeue_ready;
	logic dcache_dequeue_en;
	scalar_t dcache_dequeue_addr;
	pending_miss_state_t dcache_dequeue_state;
	logic icache_dequeue_ready;
	logic icache_dequeue_en;
	scalar_t icache_dequeue_addr;
	logic dcache_snoop_pending;
	l1_miss_entry_idx_t dcache_snoop_entry;
	pending_miss_state_t dcache_snoop_state;
	logic icache_snoop_pending;
	l1_miss_entry_idx_t icache_snoop_entry;

	l1_miss_queue dcache_miss_queue(
		.clk(clk),
		.reset(reset),
		.enqueue_en(dcache_miss),
		.enqueue_addr(dcache_miss_addr),
		.enqueue_thread_idx(dcache_miss_thread),
		.enqueue_state(dcache_miss_store ? PM_WRITE_PENDING : PM_READ_PENDING),
		.dequeue_ready(dcache_dequeue_ready),
		.dequeue_addr(dcache_dequeue_addr),
		.dequeue_state(dcache_dequeue_state),
		.dequeue_en(dcache_dequeue_en),
		.snoop_en(packet_in.valid),
		.snoop_addr(packet_in.address),
		.snoop_request_pending(dcache_snoop_pending),
		.snoop_pending_entry(dcache_snoop_entry),
		.snoop_state(dcache_snoop_state),
		.wake_en(wake.dcache_wake),
		.wake_entry(wake.dcache_wake_entry),
		.wake_oh(dcache_wake_oh));

	// Instruction misses are always reads
	l1_miss_queue icache_miss_queue(
		.clk(clk),
		.reset(reset),
		.enqueue_en(icache_miss),
		.enqueue_addr(icache_miss_addr),
		.enqueue_thread_idx(icache_miss_thread),
		.enqueue_state(PM_READ_PENDING),
		.dequeue_ready(icache_dequeue_ready),
		.dequeue_addr(icache_dequeue_addr),
		.dequeue_state(),
		.dequeue_en(icache_dequeue_en),
		.snoop_en(packet_in.valid),
		.snoop_addr(packet_in.address),
		.snoop_request_pending(icache_snoop_pending),
		.snoop_pending_entry(icache_snoop_entry),
		.snoop_state(),
		.wake_en(wake.icache_wake),
		.wake_entry(wake.icache_wake_entry),
		.wake_oh(icache_wake_oh));

	// Tag and LRU strobes follow the raw ring input
	assign dcache_addr = packet_in.address;
	assign icache_addr = packet_in.address;
	assign dcache_snoop_en = packet_in.valid && packet_in.cache_type == CT_DCACHE;
	assign dcache_snoop_set = dcache_addr.set_idx;
	assign icache_lru_read_en = packet_in.valid && packet_in.cache_type == CT_ICACHE;
	assign icache_lru_read_set = icache_addr.set_idx;

	// Occupied slots pass, empty ones carry a new request with ack clear
	always_comb
	begin
		dcache_dequeue_en = 1'b0;
		icache_dequeue_en = 1'b0;
		packet_nxt = '0;
		if (packet_in.valid)
			packet_nxt = packet_in;
		else if (dcache_dequeue_ready)
		begin
			dcache_dequeue_en = 1'b1;
			packet_nxt.valid = 1'b1;
			packet_nxt.packet_type = (dcache_dequeue_state == PM_WRITE_PENDING)
				? PKT_WRITE_INVALIDATE : PKT_READ_SHARED;
			packet_nxt.dest_core = core_id_t'(CORE_ID);
			packet_nxt.address = dcache_dequeue_addr;
			packet_nxt.cache_type = CT_DCACHE;
		end
		else if (icache_dequeue_ready)
		begin
			icache_dequeue_en = 1'b1;
			packet_nxt.valid = 1'b1;
			packet_nxt.packet_type = PKT_READ_SHARED;
			packet_nxt.dest_core = core_id_t'(CORE_ID);
			packet_nxt.address = icache_dequeue_addr;
			packet_nxt.cache_type = CT_ICACHE;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rc1.packet <= '0;
			rc1.dcache_miss_pending <= 1'b0;
			rc1.icache_miss_pending <= 1'b0;
		end
		else
		begin
			rc1.packet <= packet_nxt;
			rc1.dcache_miss_pending <= dcache_snoop_pending;
			rc1.icache_miss_pending <= icache_snoop_pending;
		end
	end

	// Lookup details, only meaningful with the pending flags
	always_ff @(posedge clk)
	begin
		rc1.dcache_miss_entry <= dcache_snoop_entry;
		rc1.dcache_miss_state <= dcache_snoop_state;
		rc1.icache_miss_entry <= icache_snoop_entry;
	end
endmodule

/* verilog/ring_if.sv */
/*
 * Links between the two ring stages. No clock inside,
 * all signals are registered by the driving stage.
 */
`timescale 1ns/1ps

// Stage 1 packet plus the miss-queue lookups made for it
interface rc1_result_if;
	import ring_pkg::*;

	ring_packet_t packet;
	logic dcache_miss_pending;
	l1_miss_entry_idx_t dcache_miss_entry;
	pending_miss_state_t dcache_miss_state;
	logic icache_miss_pending;
	l1_miss_entry_idx_t icache_miss_entry;

	modport source(output packet, dcache_miss_pending, dcache_miss_entry,
		dcache_miss_state, icache_miss_pending, icache_miss_entry);
	modport sink(input packet, dcache_miss_pending, dcache_miss_entry,
		dcache_miss_state, icache_miss_pending, icache_miss_entry);
endinterface

// One-cycle wake pulses back into the miss queues
interface miss_wake_if;
	import ring_pkg::*;

	logic dcache_wake;
	l1_miss_entry_idx_t dcache_wake_entry;
	logic icache_wake;
	l1_miss_entry_idx_t icache_wake_entry;

	modport source(output dcache_wake, dcache_wake_entry, icache_wake, icache_wake_entry);
	modport sink(input dcache_wake, dcache_wake_entry, icache_wake, icache_wake_entry);
endinterface

/* verilog/ring_params.svh */
/*
 * Ring node sizing. One miss-queue entry per hardware thread.
 * Cache geometry must keep set index and line offset within ADDR_WIDTH.
 */
`ifndef RING_PARAMS_SVH
`define RING_PARAMS_SVH

// Hardware threads in one core
`define THREADS_PER_CORE 4

// Nodes on the ring
`define NUM_CORES 4

// Line size shared by both L1 caches and the L2
`define CACHE_LINE_BYTES 64

// Sets per L1 cache
`define L1D_SETS 64
`define L1I_SETS 64

// Byte address width
`define ADDR_WIDTH 32

`endif

/* verilog/ring_pkg.sv */
/*
 * Ring bus types. Packet carries no line data.
 * Only read shared and write invalidate requests exist.
 */
`include "ring_params.svh"

package ring_pkg;
	// Derived field widths
	localparam CACHE_LINE_OFFSET_WIDTH = $clog2(`CACHE_LINE_BYTES);
	localparam L1D_SET_IDX_WIDTH = $clog2(`L1D_SETS);
	localparam L1I_SET_IDX_WIDTH = $clog2(`L1I_SETS);
	localparam L1D_TAG_WIDTH = `ADDR_WIDTH - L1D_SET_IDX_WIDTH - CACHE_LINE_OFFSET_WIDTH;
	localparam L1I_TAG_WIDTH = `ADDR_WIDTH - L1I_SET_IDX_WIDTH - CACHE_LINE_OFFSET_WIDTH;

	typedef logic [`ADDR_WIDTH - 1:0] scalar_t;
	typedef logic [$clog2(`THREADS_PER_CORE) - 1:0] thread_idx_t;
	typedef logic [$clog2(`NUM_CORES) - 1:0] core_id_t;

	// One entry per thread, so same width as a thread index
	typedef logic [$clog2(`THREADS_PER_CORE) - 1:0] l1_miss_entry_idx_t;

	typedef logic [CACHE_LINE_OFFSET_WIDTH - 1:0] cache_line_offset_t;
	typedef logic [`ADDR_WIDTH - CACHE_LINE_OFFSET_WIDTH - 1:0] cache_line_index_t;
	typedef logic [L1D_SET_IDX_WIDTH - 1:0] l1d_set_idx_t;
	typedef logic [L1D_TAG_WIDTH - 1:0] l1d_tag_t;
	typedef logic [L1I_SET_IDX_WIDTH - 1:0] l1i_set_idx_t;
	typedef logic [L1I_TAG_WIDTH - 1:0] l1i_tag_t;

	typedef struct packed {
		l1d_tag_t tag;
		l1d_set_idx_t set_idx;
		cache_line_offset_t offset;
	} l1d_addr_t;

	typedef struct packed {
		l1i_tag_t tag;
		l1i_set_idx_t set_idx;
		cache_line_offset_t offset;
	} l1i_addr_t;

	typedef enum logic [1:0] {
		PM_INVALID,
		PM_READ_PENDING,
		PM_WRITE_PENDING
	} pending_miss_state_t;

	typedef enum logic {
		CT_ICACHE,
		CT_DCACHE
	} cache_type_t;

	typedef enum logic {
		PKT_READ_SHARED,
		PKT_WRITE_INVALIDATE
	} packet_type_t;

	// An empty slot has valid low
	typedef struct packed {
		logic valid;
		packet_type_t packet_type;
		logic ack;
		core_id_t dest_core;
		scalar_t address;
		cache_type_t cache_type;
	} ring_packet_t;
endpackage

/* verilog/ring_response_stage.sv */
/*
 * Ring stage 2. Takes acknowledged responses for this core off the
 * ring and wakes the queue entry one cycle after the slot empties.
 */
`timescale 1ns/1ps

module ring_response_stage
	#(parameter CORE_ID = 0)
	(input clk,
	input reset,
	rc1_result_if.sink rc1,
	miss_wake_if.source wake,
	output ring_pkg::ring_packet_t packet_out);

	import ring_pkg::*;

	logic is_response;
	logic type_matches;
	logic dcache_response;
	logic icache_response;
	logic dcache_done;
	logic icache_done;
	l1_miss_entry_idx_t dcache_done_entry;
	l1_miss_entry_idx_t icache_done_entry;

	// Ack set and addressed here
	assign is_response = rc1.packet.valid && rc1.packet.ack
		&& rc1.packet.dest_core == core_id_t'(CORE_ID);

	// A data response must answer the request kind the entry sent
	assign type_matches = (rc1.dcache_miss_state == PM_WRITE_PENDING)
		== (rc1.packet.packet_type == PKT_WRITE_INVALIDATE);

	assign dcache_response = is_response && rc1.packet.cache_type == CT_DCACHE
		&& rc1.dcache_miss_pending && type_matches;
	assign icache_response = is_response && rc1.packet.cache_type == CT_ICACHE
		&& rc1.icache_miss_pending;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			packet_out <= '0;
			dcache_done <= 1'b0;
			icache_done <= 1'b0;
			wake.dcache_wake <= 1'b0;
			wake.icache_wake <= 1'b0;
		end
		else
		begin
			// Consumed response leaves an empty slot
			if (dcache_response || icache_response)
				packet_out <= '0;
			else
				packet_out <= rc1.packet;

			dcache_done <= dcache_response;
			icache_done <= icache_response;

			// Wake pulse trails the freed slot by one cycle
			wake.dcache_wake <= dcache_done;
			wake.icache_wake <= icache_done;
		end
	end

	always_ff @(posedge clk)
	begin
		dcache_done_entry <= rc1.dcache_miss_entry;
		icache_done_entry <= rc1.icache_miss_entry;
		wake.dcache_wake_entry <= dcache_done_entry;
		wake.icache_wake_entry <= icache_done_entry;
	end
endmodule
